// ==== source/memHandlerPkg.sv ====
`default_nettype none

package memHandlerPkg;

    localparam int WORD_W = 32;                  // Address and data width

    typedef logic [WORD_W-1:0] wordT;            // Shared address and data word

    // Access codes from the decode stage
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,                          // No memory access
        OP_LB   = 4'd1,                          // Load byte, sign extended
        OP_LH   = 4'd2,                          // Load half, sign extended
        OP_LW   = 4'd3,                          // Load word
        OP_LBU  = 4'd4,                          // Load byte, zero extended
        OP_LHU  = 4'd5,                          // Load half, zero extended
        OP_SB   = 4'd6,                          // Store byte
        OP_SH   = 4'd7,                          // Store half
        OP_SW   = 4'd8                           // Store word
    } memOp_t;

    // Command seen by the external memory
    typedef enum logic [1:0] {
        CMD_IDLE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } busCmd_t;

    // Fetch and data phases, each with its wait state
    typedef enum logic [1:0] {
        FETCH  = 2'd0,                           // Issue instruction read
        F_WAIT = 2'd1,                           // Wait for fetch to finish
        DATA   = 2'd2,                           // Issue load or store, if any
        D_WAIT = 2'd3                            // Wait for data access to finish
    } seqState_t;

endpackage

`default_nettype wire

// ==== source/memPhaseIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface memPhaseIf;

    logic reqStrobe;                             // One cycle, access issued
    logic dataPhase;                             // Access uses the ALU address
    logic captureInstr;                          // Register fetched word
    logic captureLoad;                           // Register load result
    logic accessWrite;                           // Data access is a store

    modport seq (
        output reqStrobe, dataPhase, captureInstr, captureLoad, accessWrite
    );

    // The timer only needs to know when a wait starts
    modport mon (
        input reqStrobe
    );

    modport fmt (
        input reqStrobe, dataPhase, captureInstr, captureLoad, accessWrite
    );

endinterface

`default_nettype wire

// ==== source/busyMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module busyMonitor #(
    parameter int TIMEOUT_CYCLES = 16            // Wait cycles before an access is abandoned
) (
    input  logic   clk,
    input  logic   nrst,
    input  logic   busy,                         // Busy level from memory
    memPhaseIf.mon phase,
    output logic   busyDone,                     // Busy falling edge
    output logic   waitExpired                   // Access took too long
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(TIMEOUT_CYCLES - 1);

    logic             busyQ;                     // Busy one cycle ago
    logic             waitArmed;                 // An access is outstanding
    logic [CNT_W-1:0] waitCount;                 // Cycles since the request

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busyQ <= 1'b0;
        end else begin
            busyQ <= busy;
        end
    end

    assign busyDone = busyQ & ~busy;             // High to low on busy

    // A completed access wins over a timeout in the same cycle
    assign waitExpired = waitArmed & ~busyDone & (waitCount == LAST_COUNT);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            waitArmed <= 1'b0;
            waitCount <= '0;
        end else if (phase.reqStrobe) begin
            waitArmed <= 1'b1;                   // Restart for the new access
            waitCount <= '0;
        end else if (waitArmed) begin
            if (busyDone || waitExpired) begin
                waitArmed <= 1'b0;               // Stop, count holds
            end else begin
                waitCount <= waitCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/memSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSequencer (
    input  logic   clk,
    input  logic   nrst,
    input  logic   memWrite,                     // Store requested by decode
    input  logic   memRead,                      // Load requested by decode
    input  logic   busyDone,                     // Current access finished
    input  logic   waitExpired,                  // Current access timed out
    memPhaseIf.seq phase,
    output logic   freeze,                       // Stall the CPU
    output logic   timeoutFault                  // Fault pulse on abandoned access
);

    import memHandlerPkg::*;

    seqState_t state;
    seqState_t stateNext;
    logic      loadPending;                      // D_WAIT belongs to a load
    logic      loadPendingNext;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state       <= FETCH;
            loadPending <= 1'b0;
        end else begin
            state       <= stateNext;
            loadPending <= loadPendingNext;
        end
    end

    always_comb begin
        stateNext          = state;
        loadPendingNext    = loadPending;
        phase.reqStrobe    = 1'b0;
        phase.dataPhase    = 1'b0;
        phase.captureInstr = 1'b0;
        phase.captureLoad  = 1'b0;
        phase.accessWrite  = 1'b0;
        freeze             = 1'b0;
        case (state)
            FETCH: begin
                phase.reqStrobe = nrst;          // Read at the PC once out of reset
                stateNext       = F_WAIT;
            end
            F_WAIT: begin
                freeze = 1'b1;
                if (waitExpired) begin
                    stateNext = FETCH;           // Give up without capture
                end else if (busyDone) begin
                    phase.captureInstr = 1'b1;
                    stateNext          = DATA;
                end
            end
            DATA: begin
                phase.dataPhase = 1'b1;
                if (memWrite) begin
                    phase.reqStrobe   = 1'b1;    // Store takes priority
                    phase.accessWrite = 1'b1;
                    loadPendingNext   = 1'b0;
                    stateNext         = D_WAIT;
                end else if (memRead) begin
                    phase.reqStrobe = 1'b1;
                    loadPendingNext = 1'b1;
                    stateNext       = D_WAIT;
                end else begin
                    stateNext = FETCH;           // No access this instruction
                end
            end
            D_WAIT: begin
                freeze = 1'b1;
                if (waitExpired) begin
                    stateNext = FETCH;
                end else if (busyDone) begin
                    phase.captureLoad = loadPending; // Stores capture nothing
                    stateNext         = FETCH;
                end
            end
            default: begin
                stateNext = FETCH;
            end
        endcase
    end

    assign timeoutFault = waitExpired;           // Same-cycle fault report

endmodule

`default_nettype wire

// ==== source/accessFormatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module accessFormatter (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   memSource,    // 1 stores from FPU, 0 from register file
    input  memHandlerPkg::memOp_t  memOp,
    input  memHandlerPkg::wordT    pcAddress,    // Fetch address
    input  memHandlerPkg::wordT    aluAddress,   // Load and store address
    input  memHandlerPkg::wordT    fpuData,
    input  memHandlerPkg::wordT    regData,
    input  memHandlerPkg::wordT    extData,      // Read data from memory
    memPhaseIf.fmt                 phase,
    output memHandlerPkg::busCmd_t rwi,
    output memHandlerPkg::wordT    extAddress,
    output memHandlerPkg::wordT    writeData,
    output memHandlerPkg::wordT    instr,        // Last fetched instruction
    output memHandlerPkg::wordT    dataToCpu     // Last load result
);

    import memHandlerPkg::*;

    wordT storeSrc;                              // Register chosen for a store
    wordT storeWord;                             // Store data, zero filled
    wordT loadWord;                              // Extended read data

    // Bus outputs only live in the request cycle
    always_comb begin
        rwi        = CMD_IDLE;
        extAddress = '0;
        writeData  = '0;
        if (phase.reqStrobe) begin
            extAddress = phase.dataPhase ? aluAddress : pcAddress;
            if (phase.accessWrite) begin
                rwi       = CMD_WRITE;
                writeData = storeWord;
            end else begin
                rwi = CMD_READ;
            end
        end
    end

    assign storeSrc = memSource ? fpuData : regData;

    always_comb begin
        case (memOp)
            OP_SB:   storeWord = {{(WORD_W-8){1'b0}}, storeSrc[7:0]};
            OP_SH:   storeWord = {{(WORD_W-16){1'b0}}, storeSrc[15:0]};
            OP_SW:   storeWord = storeSrc;
            default: storeWord = '0;             // Not a store
        endcase
    end

    always_comb begin
        case (memOp)
            OP_LB:   loadWord = {{(WORD_W-8){extData[7]}}, extData[7:0]};
            OP_LH:   loadWord = {{(WORD_W-16){extData[15]}}, extData[15:0]};
            OP_LW:   loadWord = extData;
            OP_LBU:  loadWord = {{(WORD_W-8){1'b0}}, extData[7:0]};
            OP_LHU:  loadWord = {{(WORD_W-16){1'b0}}, extData[15:0]};
            default: loadWord = '0;              // Not a load
        endcase
    end

    // Result registers hold until the next completed access
    always_ff @(posedge clk) begin
        if (!nrst) begin
            instr     <= '0;
            dataToCpu <= '0;
        end else begin
            if (phase.captureInstr) begin
                instr <= extData;
            end
            if (phase.captureLoad) begin
                dataToCpu <= loadWord;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cpuMemoryHandler.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuMemoryHandler #(
    parameter int TIMEOUT_CYCLES = 16            // Longest allowed wait per access
) (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   busy,         // Memory busy level
    input  logic                   memWrite,
    input  logic                   memRead,
    input  logic                   memSource,
    input  memHandlerPkg::memOp_t  memOp,
    input  memHandlerPkg::wordT    pcAddress,
    input  memHandlerPkg::wordT    aluAddress,
    input  memHandlerPkg::wordT    fpuData,
    input  memHandlerPkg::wordT    regData,
    input  memHandlerPkg::wordT    extData,
    output memHandlerPkg::wordT    writeData,
    output memHandlerPkg::wordT    extAddress,
    output memHandlerPkg::busCmd_t rwi,
    output memHandlerPkg::wordT    instr,
    output memHandlerPkg::wordT    dataToCpu,
    output logic                   freeze,
    output logic                   timeoutFault
);

    logic busyDone;                              // Access finished
    logic waitExpired;                           // Access timed out

    memPhaseIf phase ();                         // Sequencer phase controls

    busyMonitor #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) uBusyMonitor (
        .clk        (clk),
        .nrst       (nrst),
        .busy       (busy),
        .phase      (phase.mon),
        .busyDone   (busyDone),
        .waitExpired(waitExpired)
    );

    memSequencer uMemSequencer (
        .clk         (clk),
        .nrst        (nrst),
        .memWrite    (memWrite),
        .memRead     (memRead),
        .busyDone    (busyDone),
        .waitExpired (waitExpired),
        .phase       (phase.seq),
        .freeze      (freeze),
        .timeoutFault(timeoutFault)
    );

    accessFormatter uAccessFormatter (
        .clk       (clk),
        .nrst      (nrst),
        .memSource (memSource),
        .memOp     (memOp),
        .pcAddress (pcAddress),
        .aluAddress(aluAddress),
        .fpuData   (fpuData),
        .regData   (regData),
        .extData   (extData),
        .phase     (phase.fmt),
        .rwi       (rwi),
        .extAddress(extAddress),
        .writeData (writeData),
        .instr     (instr),
        .dataToCpu (dataToCpu)
    );

endmodule

`default_nettype wire

// ==== tb/tbClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int PERIOD       = 8,              // Clock period in ns
    parameter int RESET_CYCLES = 8               // Cycles with nrst held low
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 nrst = 1'b1;                          // Release just after an edge
    end

endmodule

`default_nettype wire

// ==== tb/tbMemHandler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMemHandler;

    import memHandlerPkg::*;

    localparam int TIMEOUT_CYCLES = 16;          // Wait limit given to the DUT
    localparam int MAX_LINES      = 64;

    logic    clk;
    logic    nrst;
    logic    busy;
    logic    memWrite;
    logic    memRead;
    logic    memSource;
    memOp_t  memOp;
    wordT    pcAddress;
    wordT    aluAddress;
    wordT    fpuData;
    wordT    regData;
    wordT    extData;
    wordT    writeData;
    wordT    extAddress;
    busCmd_t rwi;
    wordT    instr;
    wordT    dataToCpu;
    logic    freeze;
    logic    timeoutFault;

    // One golden column entry per vector line
    logic [3:0] gOp[MAX_LINES];
    logic       gWr[MAX_LINES];
    logic       gRd[MAX_LINES];
    logic       gSrc[MAX_LINES];
    wordT       gPc[MAX_LINES];
    wordT       gAlu[MAX_LINES];
    wordT       gFpu[MAX_LINES];
    wordT       gReg[MAX_LINES];
    wordT       gInstr[MAX_LINES];
    wordT       gLoad[MAX_LINES];
    int         gFetchLen[MAX_LINES];
    int         gDataLen[MAX_LINES];
    wordT       gExpWrite[MAX_LINES];
    wordT       gExpInstr[MAX_LINES];
    wordT       gExpData[MAX_LINES];

    int     numLines;
    int     cycleCount;
    int     cycleLimit;
    integer seed;
    wordT   pendingData;                         // dataToCpu expected at next fetch

    tbClockGen #(.PERIOD(8), .RESET_CYCLES(8)) uClockGen (.clk(clk), .nrst(nrst));

    cpuMemoryHandler #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) i_dut (
        .clk(clk), .nrst(nrst), .busy(busy), .memWrite(memWrite), .memRead(memRead),
        .memSource(memSource), .memOp(memOp), .pcAddress(pcAddress),
        .aluAddress(aluAddress), .fpuData(fpuData), .regData(regData), .extData(extData),
        .writeData(writeData), .extAddress(extAddress), .rwi(rwi), .instr(instr),
        .dataToCpu(dataToCpu), .freeze(freeze), .timeoutFault(timeoutFault)
    );

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "mismatch");
    endtask

    task automatic checkWord(input string what, input wordT got, input wordT exp);
        if (got !== exp) reportMismatch(what, got, exp);
    endtask

    task automatic checkCmd(input string what, input busCmd_t got, input busCmd_t exp);
        if (got !== exp) reportMismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) reportMismatch(what, 32'(got), 32'(exp));
    endtask

    // Advance one clock and drive just after the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    endtask

    task automatic readGolden();
        integer     fd;
        integer     got;
        string      lineBuf;
        logic [3:0] op;
        logic       wr;
        logic       rd;
        logic       src;
        wordT       pc, alu, fpu, rg, iw, lw, ew, ei, ed;
        int         fl, dl;
        fd = $fopen("tb/memHandlerGolden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("SOME TESTS FAILED");
            $fatal(1, "missing vectors");
        end
        numLines = 0;
        while (!$feof(fd)) begin
            got = $fgets(lineBuf, fd);
            if (got != 0 && lineBuf.len() > 2 && lineBuf[0] != "#") begin
                got = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %d %d %h %h %h",
                              op, wr, rd, src, pc, alu, fpu, rg, iw, lw, fl, dl, ew, ei, ed);
                if (got != 15 || numLines >= MAX_LINES) begin
                    $display("Golden vector line %0d is malformed", numLines + 1);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "bad vectors");
                end
                gOp[numLines]       = op;
                gWr[numLines]       = wr;
                gRd[numLines]       = rd;
                gSrc[numLines]      = src;
                gPc[numLines]       = pc;
                gAlu[numLines]      = alu;
                gFpu[numLines]      = fpu;
                gReg[numLines]      = rg;
                gInstr[numLines]    = iw;
                gLoad[numLines]     = lw;
                gFetchLen[numLines] = fl;
                gDataLen[numLines]  = dl;
                gExpWrite[numLines] = ew;
                gExpInstr[numLines] = ei;
                gExpData[numLines]  = ed;
                numLines++;
            end
        end
        $fclose(fd);
    endtask

    // One fetch plus its data phase from just after the FETCH edge
    task automatic runLine(input int i);
        int   pad;
        logic access;
        access     = gWr[i] | gRd[i];
        memOp      = memOp_t'(gOp[i]);
        memWrite   = gWr[i];
        memRead    = gRd[i];
        memSource  = gSrc[i];
        pcAddress  = gPc[i];
        aluAddress = gAlu[i];
        fpuData    = gFpu[i];
        regData    = gReg[i];
        busy       = 1'b0;
        extData    = '0;
        @(negedge clk);
        checkCmd("fetch command", rwi, CMD_READ);
        checkWord("fetch address", extAddress, gPc[i]);
        checkWord("write data in fetch", writeData, '0);
        checkBit("freeze in fetch", freeze, 1'b0);
        checkBit("fault in fetch", timeoutFault, 1'b0);
        checkWord("dataToCpu", dataToCpu, pendingData);
        if (!access) begin
            pad = $random(seed) & 3;             // Memory slow to react
            repeat (pad) begin
                stepCycle();
                @(negedge clk);
                checkBit("freeze before busy", freeze, 1'b1);
            end
        end
        for (int k = 1; k <= gFetchLen[i]; k++) begin
            stepCycle();
            busy = 1'b1;
            @(negedge clk);
            checkBit("freeze during fetch", freeze, 1'b1);
            checkCmd("command during fetch", rwi, CMD_IDLE);
        end
        stepCycle();
        busy    = 1'b0;
        extData = gInstr[i];                     // Valid with busy low
        @(negedge clk);
        checkBit("freeze at fetch end", freeze, 1'b1);
        stepCycle();
        extData = '0;
        @(negedge clk);
        checkWord("instr", instr, gExpInstr[i]);
        checkBit("freeze in data phase", freeze, 1'b0);
        if (!access) begin
            checkCmd("command without access", rwi, CMD_IDLE);
        end else begin
            checkCmd("data command", rwi, gWr[i] ? CMD_WRITE : CMD_READ);
            checkWord("data address", extAddress, gAlu[i]);
            checkWord("writeData", writeData, gExpWrite[i]);
            for (int k = 1; k <= gDataLen[i]; k++) begin
                stepCycle();
                busy = 1'b1;
                @(negedge clk);
                checkBit("freeze during data", freeze, 1'b1);
                checkBit("timeoutFault", timeoutFault, k == TIMEOUT_CYCLES);
                checkWord("dataToCpu during wait", dataToCpu, pendingData);
            end
            if (gDataLen[i] < TIMEOUT_CYCLES) begin
                stepCycle();
                busy    = 1'b0;
                extData = gLoad[i];
                @(negedge clk);
                checkBit("freeze at data end", freeze, 1'b1);
                checkBit("fault at data end", timeoutFault, 1'b0);
            end
        end
        stepCycle();                             // Lands in the next FETCH cycle
        busy        = 1'b0;
        extData     = '0;
        pendingData = gExpData[i];
    endtask

    initial begin
        busy        = 1'b0;
        memWrite    = 1'b0;
        memRead     = 1'b0;
        memSource   = 1'b0;
        memOp       = OP_NONE;
        pcAddress   = '0;
        aluAddress  = '0;
        fpuData     = '0;
        regData     = '0;
        extData     = '0;
        seed        = 32'hd2cd_a307;
        cycleCount  = 0;
        cycleLimit  = 0;
        pendingData = '0;
        readGolden();
        for (int i = 0; i < numLines; i++) begin
            cycleLimit += 2 * (gFetchLen[i] + gDataLen[i]) + 10;
        end
        repeat (7) @(negedge clk);               // Still in reset
        checkCmd("command in reset", rwi, CMD_IDLE);
        checkBit("freeze in reset", freeze, 1'b0);
        checkBit("fault in reset", timeoutFault, 1'b0);
        checkWord("instr in reset", instr, '0);
        checkWord("dataToCpu in reset", dataToCpu, '0);
        wait (nrst === 1'b1);
        for (int i = 0; i < numLines; i++) begin
            runLine(i);
        end
        @(negedge clk);
        checkWord("final dataToCpu", dataToCpu, pendingData);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/memHandlerGolden.txt ====
# op wr rd src pcAddr aluAddr fpuData regData instrWord loadWord fetchLen dataLen
# expWriteData expInstr expDataToCpu (hex, lengths decimal)
6 1 0 0 00000100 00002000 5E6F7081 A1B2C3D4 00A00093 00000000 1 1 000000D4 00A00093 00000000
6 1 0 1 00000104 00002001 5E6F7081 A1B2C3D4 00B00113 00000000 2 2 00000081 00B00113 00000000
7 1 0 0 00000108 00002002 5E6F7081 A1B2C3D4 00C00193 00000000 3 3 0000C3D4 00C00193 00000000
7 1 0 1 0000010C 00002004 5E6F7081 A1B2C3D4 00D00213 00000000 4 4 00007081 00D00213 00000000
8 1 0 0 00000110 00002008 5E6F7081 A1B2C3D4 00E00293 00000000 5 5 A1B2C3D4 00E00293 00000000
8 1 0 1 00000114 0000200C 5E6F7081 A1B2C3D4 00F00313 00000000 6 6 5E6F7081 00F00313 00000000
1 0 1 0 00000118 00002010 5E6F7081 A1B2C3D4 01000393 8765F4A6 7 7 00000000 01000393 FFFFFFA6
2 0 1 0 0000011C 00002014 5E6F7081 A1B2C3D4 01100413 8765F4A6 8 8 00000000 01100413 FFFFF4A6
3 0 1 0 00000120 00002018 5E6F7081 A1B2C3D4 01200493 8765F4A6 9 9 00000000 01200493 8765F4A6
4 0 1 0 00000124 0000201C 5E6F7081 A1B2C3D4 01300513 8765F4A6 10 10 00000000 01300513 000000A6
5 0 1 0 00000128 00002020 5E6F7081 A1B2C3D4 01400593 8765F4A6 1 10 00000000 01400593 0000F4A6
1 0 1 0 0000012C 00002024 5E6F7081 A1B2C3D4 01500613 12345678 10 1 00000000 01500613 00000078
2 0 1 0 00000130 00002026 5E6F7081 A1B2C3D4 01600693 12345678 2 4 00000000 01600693 00005678
0 0 0 0 00000134 00000000 5E6F7081 A1B2C3D4 01700713 00000000 3 0 00000000 01700713 00005678
3 0 1 0 00000138 00002028 5E6F7081 A1B2C3D4 01800793 DEADBEEF 4 16 00000000 01800793 00005678
4 0 1 0 0000013C 0000202C 5E6F7081 A1B2C3D4 01900813 CAFEBE80 5 2 00000000 01900813 00000080
0 0 0 1 00000140 00000000 5E6F7081 A1B2C3D4 01A00893 00000000 6 0 00000000 01A00893 00000080
3 0 1 0 00000144 00002030 5E6F7081 A1B2C3D4 01B00913 0BADF00D 7 3 00000000 01B00913 0BADF00D

// ==== vlog.f ====
source/memHandlerPkg.sv
source/memPhaseIf.sv
source/busyMonitor.sv
source/memSequencer.sv
source/accessFormatter.sv
source/cpuMemoryHandler.sv
tb/tbClockGen.sv
tb/tbMemHandler.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run, exit status reports pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module tbMemHandler -o simv
./obj_dir/simv
